/* sifh.f */
+incdir+logic
+incdir+dv
logic/sifhPkg.sv
logic/histSram.sv
logic/histBuilder.sv
logic/peakFinder.sv
logic/sifhSeq.sv
logic/sifhRegs.sv
logic/sifhTop.sv
dv/clkGen.sv
dv/sifhTb.sv

/* dv/sifhTests.svh */
// peak of each pixel from the model, lowest bin on ties
task automatic expectPeaks(input string name);
    int best;
    int bestBin;
    logic [31:0] word;
    for (int p = 0; p < `SIFH_PIXELS; p++) begin
        best = expCount[p][0];
        bestBin = 0;
        for (int b = 1; b < `SIFH_BINS; b++) begin
            if (expCount[p][b] > best) begin
                best = expCount[p][b];
                bestBin = b;
            end
        end
        cfgRead(4 + p, word);
        expectEq(name, $sformatf("pixel %0d result", p), (best << 8) | bestBin, word);
    end
endtask

task automatic expectFrameCount(input string name);
    logic [31:0] word;
    cfgRead(2, word);
    expectEq(name, "frame counter", expFrames, (word >> 8) & 8'hff);
endtask

task automatic testReset();
    string name;
    logic [31:0] word;
    name = "reset";
    expectEq(name, "tdcEn", 0, tdcEn);
    expectEq(name, "frameDone", 0, frameDone);
    for (int a = 0; a < 8; a++) begin
        cfgRead(a, word);
        expectEq(name, $sformatf("register %0d", a), (a == 1) ? `SIFH_SHOTS_DEFAULT : 0, word);
    end
    repeat (20) begin                          // idle while run is 0
        expectTdcLow(name);
        @(negedge clk);
    end
endtask

task automatic testSingleFrame();
    string name;
    logic [31:0] word;
    name = "singleFrame";
    clearModel();
    addHits(0, 10, 8);
    addHits(0, 11, 3);
    addHits(0, 40, 2);
    addHits(1, 63, 7);
    addHits(1, 5, 4);
    addHits(2, 0, 6);
    addHits(2, 31, 2);
    addHits(3, 22, 9);
    addHits(3, 23, 5);
    cfgWrite(1, hitPixQ.size());
    cfgWrite(0, 1);
    sendHits(name, hitPixQ.size(), 3);
    expectTdcLow(name);                        // frame length reached
    waitFrame();
    expectPeaks(name);
    cfgRead(2, word);
    expectEq(name, "frame counter", 1, (word >> 8) & 8'hff);
    expectEq(name, "busy", 1, word & 1);
endtask

// same bin on consecutive cycles exercises the write forwarding
task automatic testBackToBack();
    string name;
    name = "backToBack";
    clearModel();
    addHits(0, 20, 5);
    addHits(0, 21, 3);
    addHits(0, 20, 4);
    addHits(0, 19, 2);
    addHits(0, 20, 3);
    addHits(1, 33, 6);
    addHits(1, 32, 6);
    addHits(1, 33, 1);
    addHits(2, 8, 2);
    addHits(2, 9, 1);
    addHits(2, 8, 2);
    addHits(3, 50, 10);
    cfgWrite(1, hitPixQ.size());
    sendHits(name, hitPixQ.size(), 0);
    expectTdcLow(name);
    waitFrame();
    expectPeaks(name);
    expectFrameCount(name);
endtask

task automatic testTiesEmpty();
    string name;
    name = "tiesEmpty";
    clearModel();
    addHits(0, 30, 5);                         // higher bin first
    addHits(0, 7, 5);
    addHits(2, 13, 3);
    addHits(2, 2, 1);
    addHits(2, 12, 3);
    addHits(3, 63, 1);                         // pixel 1 gets nothing
    cfgWrite(1, hitPixQ.size());
    sendHits(name, hitPixQ.size(), 2);
    waitFrame();
    expectPeaks(name);
    expectFrameCount(name);
endtask

task automatic testSaturation();
    string name;
    name = "saturation";
    clearModel();
    addHits(2, 45, 300);
    cfgWrite(1, 300);
    sendHits(name, 300, 0);
    expectTdcLow(name);
    waitFrame();
    expectPeaks(name);
    expectFrameCount(name);
endtask

task automatic testIsolationStop();
    string name;
    logic [31:0] word;
    name = "isolation";
    clearModel();
    addHits(2, 3, 6);                          // bin 45 of pixel 2 was full last frame
    addHits(0, 45, 4);
    addHits(3, 20, 2);
    cfgWrite(1, hitPixQ.size());
    sendHits(name, hitPixQ.size(), 1);
    waitFrame();
    expectPeaks(name);
    expectFrameCount(name);

    name = "stop";
    clearModel();
    addHits(1, 9, 15);
    addHits(1, 10, 5);
    addHits(3, 60, 12);
    addHits(0, 1, 8);
    cfgWrite(1, 40);
    sendHits(name, 20, 1);
    cfgWrite(0, 0);                            // run dropped mid frame
    sendHits(name, 20, 1);
    expectTdcLow(name);
    waitFrame();
    expectPeaks(name);
    cfgRead(2, word);
    expectEq(name, "status", expFrames << 8, word);
    cfgRead(0, word);
    expectEq(name, "control", 0, word);
    repeat (50) begin
        expectTdcLow(name);
        expectEq(name, "frameDone", 0, frameDone);
        @(negedge clk);
    end
    expectFrameCount(name);
endtask

/* dv/sifhTb.sv */
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module sifhTb import sifhPkg::*; ();

    localparam int CLK_NS = 100;
    localparam int FRAMES = 8;                 // frames run over all tests, rounded up
    localparam int FRAME_CYCLES = 1250;        // clear + hits with gaps + drain + peak scan
    localparam int WATCHDOG_NS = 2 * FRAMES * FRAME_CYCLES * CLK_NS;
    localparam int MAX_COUNT = (1 << `SIFH_COUNT_W) - 1;

    logic clk;
    logic res;
    logic hit;
    pixIdxT hitPixel;
    binIdxT hitBin;
    logic cfgWe;
    logic [2:0] cfgAddr;
    logic [`SIFH_REG_W-1:0] cfgWdata;
    logic [`SIFH_REG_W-1:0] cfgRdata;
    logic tdcEn;
    logic frameDone;

    int errors;
    int checks;
    int expFrames;
    integer seed = 92198;
    int expCount [`SIFH_PIXELS][`SIFH_BINS];   // reference histograms
    int hitPixQ [$];
    int hitBinQ [$];

    clkGen #(.PERIOD_NS(CLK_NS), .RES_CYCLES(4)) clocks (.clk(clk), .res(res));

    sifhTop uut (
        .clk(clk), .res(res),
        .hit(hit), .hitPixel(hitPixel), .hitBin(hitBin),
        .cfgWe(cfgWe), .cfgAddr(cfgAddr), .cfgWdata(cfgWdata), .cfgRdata(cfgRdata),
        .tdcEn(tdcEn), .frameDone(frameDone)
    );

    // unknown bits in the actual value count as a mismatch
    task automatic expectEq(input string name, input string what, input int exp,
                            input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", name, what, exp, act);
        end
    endtask

    // bus tasks start and end on a falling edge
    task automatic cfgWrite(input int addr, input int data);
        cfgAddr = 3'(addr);
        cfgWdata = `SIFH_REG_W'(data);
        cfgWe = 1'b1;
        @(negedge clk);
        cfgWe = 1'b0;
    endtask

    task automatic cfgRead(input int addr, output logic [31:0] data);
        cfgAddr = 3'(addr);
        #10;
        data = cfgRdata;
        @(negedge clk);
    endtask

    task automatic clearModel();
        for (int p = 0; p < `SIFH_PIXELS; p++) begin
            for (int b = 0; b < `SIFH_BINS; b++) begin
                expCount[p][b] = 0;
            end
        end
        hitPixQ.delete();
        hitBinQ.delete();
    endtask

    // queue n hits and apply them to the model with saturation
    task automatic addHits(input int pix, input int bin, input int n);
        for (int i = 0; i < n; i++) begin
            hitPixQ.push_back(pix);
            hitBinQ.push_back(bin);
            if (expCount[pix][bin] < MAX_COUNT) expCount[pix][bin]++;
        end
    endtask

    task automatic sendHits(input string name, input int n, input int gapMax);
        int gap;
        int pix;
        int bin;
        while (tdcEn !== 1'b1) @(negedge clk);
        for (int i = 0; i < n; i++) begin
            pix = hitPixQ.pop_front();
            bin = hitBinQ.pop_front();
            checks++;
            if (tdcEn !== 1'b1) begin
                errors++;
                $display("[ERROR] %s: tdcEn was low when hit %0d was sent", name, i);
            end
            hit = 1'b1;
            hitPixel = pixIdxT'(pix);
            hitBin = binIdxT'(bin);
            @(negedge clk);
            hit = 1'b0;
            gap = ($random(seed) & 32'h7fffffff) % (gapMax + 1);
            repeat (gap) @(negedge clk);
        end
    endtask

    // returns one cycle after frameDone, once the frame counter has moved
    task automatic waitFrame();
        while (frameDone !== 1'b1) @(negedge clk);
        @(negedge clk);
        expFrames++;
    endtask

    task automatic expectTdcLow(input string name);
        checks++;
        if (tdcEn !== 1'b0) begin
            errors++;
            $display("[ERROR] %s: tdcEn is high when no hits are wanted", name);
        end
    endtask

    `include "sifhTests.svh"

    initial begin
        hit = 1'b0;
        hitPixel = '0;
        hitBin = '0;
        cfgWe = 1'b0;
        cfgAddr = '0;
        cfgWdata = '0;
        errors = 0;
        checks = 0;
        expFrames = 0;
        wait (res === 1'b1);
        @(negedge clk);
        testReset();
        testSingleFrame();
        testBackToBack();
        testTiesEmpty();
        testSaturation();
        testIsolationStop();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* dv/clkGen.sv */
`timescale 1ns/1ps

module clkGen #(
    parameter int PERIOD_NS  = 100,
    parameter int RES_CYCLES = 4
) (
    output logic clk,
    output logic res
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset released on a falling edge, away from the sampling edge
    initial begin
        res = 1'b0;
        repeat (RES_CYCLES) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
    end

endmodule

/* logic/sifhTop.sv */
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module sifhTop import sifhPkg::*; (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   hit,
    input  pixIdxT                 hitPixel,
    input  binIdxT                 hitBin,
    input  logic                   cfgWe,
    input  logic [2:0]             cfgAddr,
    input  logic [`SIFH_REG_W-1:0] cfgWdata,
    output logic [`SIFH_REG_W-1:0] cfgRdata,
    output logic                   tdcEn,
    output logic                   frameDone
);

    logic run;
    logic [`SIFH_REG_W-1:0] shotsPerFrame;
    logic busy;
    logic acceptHit;
    logic peakStart;
    logic peakDone;
    ramAddrT buildWaddr;
    countT buildWdata;
    logic buildWe;
    ramAddrT buildRaddr;
    logic buildRe;
    ramAddrT peakRaddr;
    logic peakRe;
    logic resValid;
    pixIdxT resPixel;
    binIdxT resBin;
    countT resCount;
    ramAddrT waddr;
    countT wdata;
    logic wEnable;
    ramAddrT raddr;
    logic rEnable;
    countT rdata;                           // shared by builder and peak finder

    sifhRegs regs (
        .clk(clk), .res(res),
        .cfgWe(cfgWe), .cfgAddr(cfgAddr), .cfgWdata(cfgWdata), .cfgRdata(cfgRdata),
        .busy(busy), .frameDone(frameDone),
        .resValid(resValid), .resPixel(resPixel), .resBin(resBin), .resCount(resCount),
        .run(run), .shotsPerFrame(shotsPerFrame)
    );

    sifhSeq seq (
        .clk(clk), .res(res),
        .run(run), .shotsPerFrame(shotsPerFrame), .hit(hit),
        .buildWaddr(buildWaddr), .buildWdata(buildWdata), .buildWe(buildWe),
        .buildRaddr(buildRaddr), .buildRe(buildRe),
        .peakRaddr(peakRaddr), .peakRe(peakRe), .peakDone(peakDone),
        .phase(), .tdcEn(tdcEn), .acceptHit(acceptHit), .peakStart(peakStart),
        .busy(busy), .frameDone(frameDone),
        .waddr(waddr), .wdata(wdata), .wEnable(wEnable),
        .raddr(raddr), .rEnable(rEnable)
    );

    histBuilder builder (
        .clk(clk), .res(res),
        .acceptHit(acceptHit), .hitPixel(hitPixel), .hitBin(hitBin), .rdata(rdata),
        .buildRaddr(buildRaddr), .buildRe(buildRe),
        .buildWaddr(buildWaddr), .buildWdata(buildWdata), .buildWe(buildWe)
    );

    peakFinder finder (
        .clk(clk), .res(res),
        .peakStart(peakStart), .rdata(rdata),
        .peakRaddr(peakRaddr), .peakRe(peakRe),
        .resValid(resValid), .resPixel(resPixel), .resBin(resBin), .resCount(resCount),
        .peakDone(peakDone)
    );

    histSram sram (
        .clk(clk),
        .waddr(waddr), .wdata(wdata), .wEnable(wEnable),
        .raddr(raddr), .rEnable(rEnable), .rdata(rdata)
    );

endmodule

/* logic/sifhRegs.sv */
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module sifhRegs import sifhPkg::*; (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   cfgWe,
    input  logic [2:0]             cfgAddr,
    input  logic [`SIFH_REG_W-1:0] cfgWdata,
    input  logic                   busy,
    input  logic                   frameDone,
    input  logic                   resValid,
    input  pixIdxT                 resPixel,
    input  binIdxT                 resBin,
    input  countT                  resCount,
    output logic [`SIFH_REG_W-1:0] cfgRdata,
    output logic                   run,
    output logic [`SIFH_REG_W-1:0] shotsPerFrame
);

    logic [7:0] frameCnt;
    binIdxT slotBin [`SIFH_PIXELS];
    countT  slotCount [`SIFH_PIXELS];
    pixIdxT rdSlot;

    assign rdSlot = pixIdxT'(cfgAddr);    // 4..7 map to pixel 0..3

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            run <= 1'b0;
            shotsPerFrame <= `SIFH_REG_W'(`SIFH_SHOTS_DEFAULT);
            frameCnt <= '0;
            for (int i = 0; i < `SIFH_PIXELS; i++) begin
                slotBin[i] <= '0;
                slotCount[i] <= '0;
            end
        end else begin
            if (cfgWe && cfgAddr == 3'd0) run <= cfgWdata[0];
            if (cfgWe && cfgAddr == 3'd1) shotsPerFrame <= cfgWdata;
            if (frameDone) frameCnt <= frameCnt + 1'b1;
            if (resValid) begin
                slotBin[resPixel] <= resBin;        // kept until the next frame
                slotCount[resPixel] <= resCount;
            end
        end
    end

    // read mux
    always_comb begin
        cfgRdata = '0;
        case (cfgAddr)
            3'd0: cfgRdata[0] = run;
            3'd1: cfgRdata = shotsPerFrame;
            3'd2: begin
                cfgRdata[0] = busy;
                cfgRdata[15:8] = frameCnt;
            end
            3'd4, 3'd5, 3'd6, 3'd7: begin
                cfgRdata[15:8] = slotCount[rdSlot];
                cfgRdata[5:0] = slotBin[rdSlot];
            end
            default: ;
        endcase
    end

endmodule

/* logic/sifhSeq.sv */
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module sifhSeq import sifhPkg::*; (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  run,
    input  logic [`SIFH_REG_W-1:0] shotsPerFrame,
    input  logic                  hit,
    input  ramAddrT               buildWaddr,
    input  countT                 buildWdata,
    input  logic                  buildWe,
    input  ramAddrT               buildRaddr,
    input  logic                  buildRe,
    input  ramAddrT               peakRaddr,
    input  logic                  peakRe,
    input  logic                  peakDone,
    output seqPhaseT              phase,
    output logic                  tdcEn,
    output logic                  acceptHit,
    output logic                  peakStart,
    output logic                  busy,
    output logic                  frameDone,
    output ramAddrT               waddr,
    output countT                 wdata,
    output logic                  wEnable,
    output ramAddrT               raddr,
    output logic                  rEnable
);

    localparam int DRAIN = 2;   // builder pipeline depth after the last hit

    seqPhaseT nextPhase;
    ramAddrT  clrAddr;
    logic [`SIFH_REG_W-1:0] hitCnt;
    logic [$clog2(DRAIN)-1:0] drainCnt;
    logic     shotsReached;
    logic     drained;

    assign shotsReached = (hitCnt >= shotsPerFrame);
    assign drained = shotsReached && (drainCnt == DRAIN - 1);

    // tdc converts only while hits are still wanted
    assign tdcEn = (phase == BUILD) && !shotsReached;
    assign acceptHit = hit && tdcEn;
    assign busy = (phase != IDLE);
    assign frameDone = (phase == PEAK) && peakDone;
    assign peakStart = (phase == BUILD) && drained;  // on the edge into PEAK

    always_comb begin
        nextPhase = phase;
        case (phase)
            IDLE:  if (run) nextPhase = CLEAR;
            CLEAR: if (clrAddr == '1) nextPhase = BUILD;
            BUILD: if (drained) nextPhase = PEAK;
            PEAK:  if (peakDone) nextPhase = run ? CLEAR : IDLE;
            default: nextPhase = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase <= IDLE;
            clrAddr <= '0;
            hitCnt <= '0;
            drainCnt <= '0;
        end else begin
            phase <= nextPhase;
            if (phase == CLEAR) begin
                clrAddr <= clrAddr + 1'b1;      // wraps back to 0 at the end
            end
            if (phase != BUILD) begin
                hitCnt <= '0;
                drainCnt <= '0;
            end else if (acceptHit) begin
                hitCnt <= hitCnt + 1'b1;
            end else if (shotsReached) begin
                drainCnt <= drainCnt + 1'b1;
            end
        end
    end

    // sram port ownership by phase
    always_comb begin
        waddr = '0;
        wdata = '0;
        wEnable = 1'b0;
        raddr = '0;
        rEnable = 1'b0;
        case (phase)
            CLEAR: begin
                waddr = clrAddr;
                wEnable = 1'b1;             // zero data
            end
            BUILD: begin
                waddr = buildWaddr;
                wdata = buildWdata;
                wEnable = buildWe;
                raddr = buildRaddr;
                rEnable = buildRe;
            end
            PEAK: begin
                raddr = peakRaddr;          // read only
                rEnable = peakRe;
            end
            default: ;
        endcase
    end

endmodule

/* logic/peakFinder.sv */
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module peakFinder import sifhPkg::*; (
    input  logic    clk,
    input  logic    res,
    input  logic    peakStart,
    input  countT   rdata,
    output ramAddrT peakRaddr,
    output logic    peakRe,
    output logic    resValid,
    output pixIdxT  resPixel,
    output binIdxT  resBin,
    output countT   resCount,
    output logic    peakDone
);

    localparam int LAST_STEP = `SIFH_BINS + 1;  // result posted here

    logic   running;
    pixIdxT pix;
    logic [$clog2(`SIFH_BINS + 2)-1:0] step;    // 0..BINS-1 read, then 2 settle
    logic   dValid;                             // rdata holds bin dBin
    binIdxT dBin;
    countT  best;
    binIdxT bestBin;

    assign peakRe = running && (step < `SIFH_BINS);
    assign peakRaddr = {pix, binIdxT'(step)};

    assign resValid = running && (step == LAST_STEP);
    assign resPixel = pix;
    assign resBin = bestBin;
    assign resCount = best;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            running <= 1'b0;
            pix <= '0;
            step <= '0;
            dValid <= 1'b0;
            peakDone <= 1'b0;
        end else begin
            dValid <= peakRe;
            peakDone <= resValid && (pix == pixIdxT'(`SIFH_PIXELS - 1));
            if (peakStart) begin
                running <= 1'b1;
                pix <= '0;
                step <= '0;
            end else if (running) begin
                if (step == LAST_STEP) begin
                    step <= '0;
                    pix <= pix + 1'b1;
                    if (pix == pixIdxT'(`SIFH_PIXELS - 1)) begin
                        running <= 1'b0;            // all pixels scanned
                    end
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // running best, strictly greater keeps the lowest bin on ties
    always_ff @(posedge clk) begin
        dBin <= binIdxT'(step);
        if (dValid) begin
            if (dBin == '0 || rdata > best) begin
                best <= rdata;
                bestBin <= dBin;
            end
        end
    end

endmodule

/* logic/histBuilder.sv */
`timescale 1ns/1ps

module histBuilder import sifhPkg::*; (
    input  logic    clk,
    input  logic    res,
    input  logic    acceptHit,
    input  pixIdxT  hitPixel,
    input  binIdxT  hitBin,
    input  countT   rdata,
    output ramAddrT buildRaddr,
    output logic    buildRe,
    output ramAddrT buildWaddr,
    output countT   buildWdata,
    output logic    buildWe
);

    ramAddrT hitAddr;
    logic    pendValid;     // read in flight, write due this cycle
    ramAddrT pendAddr;
    logic    fwdValid;      // sram data for pendAddr is stale
    countT   fwdData;
    countT   baseCount;

    assign hitAddr = {hitPixel, hitBin};

    // read issued in the hit cycle
    assign buildRaddr = hitAddr;
    assign buildRe = acceptHit;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pendValid <= 1'b0;
            fwdValid <= 1'b0;
        end else begin
            pendValid <= acceptHit;
            // this hit reads the same word that is being written right now
            fwdValid <= acceptHit && pendValid && (pendAddr == hitAddr);
        end
    end

    always_ff @(posedge clk) begin
        pendAddr <= hitAddr;
        fwdData <= buildWdata;
    end

    assign baseCount = fwdValid ? fwdData : rdata;

    // saturating increment
    assign buildWdata = (baseCount == '1) ? baseCount : baseCount + 1'b1;
    assign buildWaddr = pendAddr;
    assign buildWe = pendValid;

endmodule

/* logic/histSram.sv */
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module histSram import sifhPkg::*; (
    input  logic    clk,
    input  ramAddrT waddr,
    input  countT   wdata,
    input  logic    wEnable,
    input  ramAddrT raddr,
    input  logic    rEnable,
    output countT   rdata
);

    // one histogram per pixel, stacked by pixel index
    countT mem [`SIFH_PIXELS * `SIFH_BINS];

    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, old data on a same-address collision
    always_ff @(posedge clk) begin
        if (rEnable) begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* logic/sifhPkg.sv */
`include "sifh_cfg.svh"

package sifhPkg;

    // pixel and bin indices
    typedef logic [$clog2(`SIFH_PIXELS)-1:0] pixIdxT;
    typedef logic [$clog2(`SIFH_BINS)-1:0] binIdxT;

    // pixel in the upper bits, bin in the lower bits
    typedef logic [$clog2(`SIFH_PIXELS * `SIFH_BINS)-1:0] ramAddrT;

    typedef logic [`SIFH_COUNT_W-1:0] countT;

    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        BUILD,
        PEAK
    } seqPhaseT;

endpackage

/* logic/sifh_cfg.svh */
`ifndef SIFH_CFG_SVH
`define SIFH_CFG_SVH

// array geometry
`define SIFH_PIXELS 4
`define SIFH_BINS 64

// counters saturate at 2**SIFH_COUNT_W - 1
`define SIFH_COUNT_W 8

// register bus
`define SIFH_REG_W 16

// hits per frame after reset
`define SIFH_SHOTS_DEFAULT 100

`endif
